//--- common/hart_pkg.sv
package hart_pkg;

    // Core configuration
    localparam int HART_NUM   = 4;
    localparam int HART_ID_W  = 2;
    localparam int HART_SST_W = 2;

    // Per-hart run state
    localparam logic [HART_SST_W-1:0] SST_IDLE   = 2'd0;
    localparam logic [HART_SST_W-1:0] SST_ACTIVE = 2'd1;
    localparam logic [HART_SST_W-1:0] SST_PEND   = 2'd2;  // Waiting on a cache refill

    // Only this hart runs out of reset
    localparam logic [HART_ID_W-1:0] RESET_HART = 2'd0;

    // Hart id to one-hot hart vector
    function automatic logic [HART_NUM-1:0] hart_onehot(
        input logic [HART_ID_W-1:0] hid
    );
        logic [HART_NUM-1:0] oh;
        oh      = '0;
        oh[hid] = 1'b1;
        return oh;
    endfunction

endpackage

//--- common/hart_sched_if.sv
`timescale 1ns/1ps

interface hart_sched_if import hart_pkg::*; ();

    logic [HART_NUM-1:0]  acti_hstate;  // Harts able to issue
    logic [HART_NUM-1:0]  prim_hstate;  // One-hot issue hart, zero when none
    logic [HART_ID_W-1:0] issue_hid;
    logic                 ic_stall;
    logic                 dc_stall;

    // Run-state side
    modport state_mp (
        output acti_hstate,
        output ic_stall,
        output dc_stall,
        input  prim_hstate,
        input  issue_hid
    );

    // Issue selection side
    modport switch_mp (
        input  acti_hstate,
        input  ic_stall,
        input  dc_stall,
        output prim_hstate,
        output issue_hid
    );

endinterface

//--- hart_state/hart_state.sv
`timescale 1ns/1ps

module hart_state import hart_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    // Decode stage
    input  logic                  i_id_hstart,
    input  logic                  i_id_hkill,
    input  logic [HART_ID_W-1:0]  i_id_set_hid,
    output logic [HART_SST_W-1:0] o_hart_val,     // Run state of i_id_set_hid
    output logic                  o_hart_idle,
    output logic [HART_NUM-1:0]   o_idle_hstate,

    // I-cache
    input  logic                  i_icache_miss,  // Applies to the issue hart
    input  logic                  i_icache_fin,
    input  logic [HART_ID_W-1:0]  i_icache_fin_hid,

    // D-cache
    input  logic                  i_dcache_miss,
    input  logic [HART_ID_W-1:0]  i_ex_hart_id,
    input  logic                  i_dcache_fin,
    input  logic [HART_ID_W-1:0]  i_dcache_fin_hid,

    hart_sched_if.state_mp        sched
);

    logic [HART_SST_W-1:0] sst_q   [HART_NUM];
    logic [HART_SST_W-1:0] sst_nxt [HART_NUM];
    logic [HART_NUM-1:0]   pend_dc_q;   // Pending cause, 1 for d-cache, 0 for i-cache
    logic [HART_NUM-1:0]   pend_dc_nxt;

    logic [HART_NUM-1:0]   start_hit;
    logic [HART_NUM-1:0]   kill_hit;
    logic [HART_NUM-1:0]   icm_hit;
    logic [HART_NUM-1:0]   dcm_hit;
    logic [HART_NUM-1:0]   icf_hit;
    logic [HART_NUM-1:0]   dcf_hit;

    logic [HART_NUM-1:0]   acti_vec;
    logic [HART_NUM-1:0]   idle_vec;
    logic [HART_NUM-1:0]   pend_ic_vec;
    logic [HART_NUM-1:0]   pend_dc_vec;

    // Strobes decoded to the hart they address
    assign start_hit = i_id_hstart  ? hart_onehot(i_id_set_hid)     : '0;
    assign kill_hit  = i_id_hkill   ? hart_onehot(i_id_set_hid)     : '0;
    assign dcm_hit   = i_dcache_miss ? hart_onehot(i_ex_hart_id)    : '0;
    assign icf_hit   = i_icache_fin ? hart_onehot(i_icache_fin_hid) : '0;
    assign dcf_hit   = i_dcache_fin ? hart_onehot(i_dcache_fin_hid) : '0;

    // No issue hart right after reset, so an i-cache miss there has no owner
    assign icm_hit = (i_icache_miss && |sched.prim_hstate) ? hart_onehot(sched.issue_hid) : '0;

    always_comb begin
        for (int h = 0; h < HART_NUM; h++) begin
            sst_nxt[h]     = sst_q[h];
            pend_dc_nxt[h] = pend_dc_q[h];
            if (kill_hit[h]) begin
                sst_nxt[h] = SST_IDLE;                      // Kill wins over everything
            end else if (icm_hit[h] && sst_q[h] == SST_ACTIVE) begin
                sst_nxt[h]     = SST_PEND;
                pend_dc_nxt[h] = 1'b0;
            end else if (dcm_hit[h] && sst_q[h] == SST_ACTIVE) begin
                sst_nxt[h]     = SST_PEND;
                pend_dc_nxt[h] = 1'b1;
            end else if (icf_hit[h] && sst_q[h] == SST_PEND && !pend_dc_q[h]) begin
                sst_nxt[h] = SST_ACTIVE;
            end else if (dcf_hit[h] && sst_q[h] == SST_PEND && pend_dc_q[h]) begin
                sst_nxt[h] = SST_ACTIVE;
            end else if (start_hit[h] && sst_q[h] == SST_IDLE) begin
                sst_nxt[h] = SST_ACTIVE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int h = 0; h < HART_NUM; h++) begin
                sst_q[h] <= (h == int'(RESET_HART)) ? SST_ACTIVE : SST_IDLE;
            end
        end else begin
            for (int h = 0; h < HART_NUM; h++) begin
                sst_q[h] <= sst_nxt[h];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pend_dc_q <= '0;
        end else begin
            pend_dc_q <= pend_dc_nxt;
        end
    end

    always_comb begin
        for (int h = 0; h < HART_NUM; h++) begin
            acti_vec[h]    = (sst_q[h] == SST_ACTIVE);
            idle_vec[h]    = (sst_q[h] == SST_IDLE);
            pend_ic_vec[h] = (sst_q[h] == SST_PEND) && !pend_dc_q[h];
            pend_dc_vec[h] = (sst_q[h] == SST_PEND) && pend_dc_q[h];
        end
    end

    assign sched.acti_hstate = acti_vec;
    assign o_idle_hstate     = idle_vec;

    // Nothing left to run, wait for the refill
    assign sched.ic_stall = ~|acti_vec & |pend_ic_vec;
    assign sched.dc_stall = ~|acti_vec & |pend_dc_vec;

    // Decode stage queries
    assign o_hart_val  = sst_q[i_id_set_hid];
    assign o_hart_idle = idle_vec[i_id_set_hid];

endmodule

//--- hart_switch/hart_switch.sv
`timescale 1ns/1ps

module hart_switch import hart_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst,

    // Decode stage
    input  logic                 i_is_branch,
    input  logic                 i_is_load,
    input  logic [HART_ID_W-1:0] i_if_hart_id,

    // Cache misses
    input  logic                 i_icache_miss,
    input  logic                 i_dcache_miss,
    input  logic [HART_ID_W-1:0] i_ex_hart_id,

    output logic [HART_NUM-1:0]  o_issue_hstate,
    output logic                 o_hart_ic_flush,
    output logic                 o_hart_dc_flush,

    hart_sched_if.switch_mp      sched
);

    logic [HART_NUM-1:0]  prim_q;        // One-hot primary hart
    logic [HART_NUM-1:0]  prim_nxt;
    logic [HART_ID_W-1:0] prim_id;
    logic [HART_NUM-1:0]  acti;
    logic [HART_NUM-1:0]  rot_acti;      // Bit k is hart prim_id + 1 + k
    logic                 sel_vld;
    logic [HART_ID_W-1:0] sel_ofs;
    logic [HART_ID_W-1:0] sel_id;
    logic                 prim_lost;
    logic                 sw_req;
    logic [HART_NUM-1:0]  ex_oh;

    assign acti = sched.acti_hstate;

    // Primary one-hot to id
    always_comb begin
        case (prim_q)
            4'b0001: prim_id = 2'd0;
            4'b0010: prim_id = 2'd1;
            4'b0100: prim_id = 2'd2;
            4'b1000: prim_id = 2'd3;
            default: prim_id = 2'd0;  // No primary
        endcase
    end

    // Active set rotated to start just after the primary
    always_comb begin
        for (int k = 0; k < HART_NUM; k++) begin
            rot_acti[k] = acti[(int'(prim_id) + 1 + k) % HART_NUM];
        end
    end

    // First active hart in rotating order, the primary itself comes last
    always_comb begin
        sel_vld = 1'b1;
        casez (rot_acti)
            4'b???1: sel_ofs = 2'd0;
            4'b??10: sel_ofs = 2'd1;
            4'b?100: sel_ofs = 2'd2;
            4'b1000: sel_ofs = 2'd3;
            default: begin
                sel_ofs = 2'd0;
                sel_vld = 1'b0;
            end
        endcase
    end

    assign sel_id   = prim_id + HART_ID_W'(1) + sel_ofs;  // Wraps around the hart ring
    assign prim_nxt = sel_vld ? hart_onehot(sel_id) : '0;

    // Primary parked, killed or not yet chosen
    assign prim_lost = ~|(prim_q & acti);

    // Hide branch or load latency behind another hart
    assign sw_req = (i_is_branch | i_is_load) && (i_if_hart_id == prim_id) && |prim_q
                    && !sched.ic_stall && !sched.dc_stall;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            prim_q <= '0;
        end else if (prim_lost || sw_req) begin
            prim_q <= prim_nxt;
        end
    end

    assign o_issue_hstate    = prim_q;
    assign sched.prim_hstate = prim_q;
    assign sched.issue_hid   = prim_id;

    // Flush only when the miss is taken and another hart can run
    assign ex_oh = hart_onehot(i_ex_hart_id);

    assign o_hart_ic_flush = i_icache_miss && |(prim_q & acti) && |(acti & ~prim_q);
    assign o_hart_dc_flush = i_dcache_miss && |(ex_oh & acti) && |(acti & ~ex_oh);

endmodule

//--- design/hart_ctrl.sv
`timescale 1ns/1ps

module hart_ctrl import hart_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    // Decode stage
    input  logic                  i_id_hstart,
    input  logic                  i_id_hkill,
    input  logic [HART_ID_W-1:0]  i_id_set_hid,
    input  logic                  i_is_branch,
    input  logic                  i_is_load,
    input  logic [HART_ID_W-1:0]  i_if_hart_id,

    // I-cache
    input  logic                  i_icache_miss,
    input  logic                  i_icache_fin,
    input  logic [HART_ID_W-1:0]  i_icache_fin_hid,

    // D-cache
    input  logic                  i_dcache_miss,
    input  logic [HART_ID_W-1:0]  i_ex_hart_id,
    input  logic                  i_dcache_fin,
    input  logic [HART_ID_W-1:0]  i_dcache_fin_hid,

    output logic [HART_SST_W-1:0] o_hart_val,     // 2 pend, 1 active, 0 idle
    output logic                  o_hart_idle,
    output logic [HART_NUM-1:0]   o_acti_hstate,
    output logic [HART_NUM-1:0]   o_idle_hstate,
    output logic [HART_NUM-1:0]   o_issue_hstate,
    output logic [HART_ID_W-1:0]  o_issue_hid,
    output logic                  o_hart_ic_stall,
    output logic                  o_hart_dc_stall,
    output logic                  o_hart_ic_flush,
    output logic                  o_hart_dc_flush
);

    hart_sched_if sched ();

    hart_state u_hart_state (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_id_hstart      (i_id_hstart),
        .i_id_hkill       (i_id_hkill),
        .i_id_set_hid     (i_id_set_hid),
        .o_hart_val       (o_hart_val),
        .o_hart_idle      (o_hart_idle),
        .o_idle_hstate    (o_idle_hstate),
        .i_icache_miss    (i_icache_miss),
        .i_icache_fin     (i_icache_fin),
        .i_icache_fin_hid (i_icache_fin_hid),
        .i_dcache_miss    (i_dcache_miss),
        .i_ex_hart_id     (i_ex_hart_id),
        .i_dcache_fin     (i_dcache_fin),
        .i_dcache_fin_hid (i_dcache_fin_hid),
        .sched            (sched.state_mp)
    );

    hart_switch u_hart_switch (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_is_branch     (i_is_branch),
        .i_is_load       (i_is_load),
        .i_if_hart_id    (i_if_hart_id),
        .i_icache_miss   (i_icache_miss),
        .i_dcache_miss   (i_dcache_miss),
        .i_ex_hart_id    (i_ex_hart_id),
        .o_issue_hstate  (o_issue_hstate),
        .o_hart_ic_flush (o_hart_ic_flush),
        .o_hart_dc_flush (o_hart_dc_flush),
        .sched           (sched.switch_mp)
    );

    // Scheduling signals seen by the pipeline
    assign o_acti_hstate   = sched.acti_hstate;
    assign o_issue_hid     = sched.issue_hid;
    assign o_hart_ic_stall = sched.ic_stall;
    assign o_hart_dc_stall = sched.dc_stall;

endmodule

//--- verif/hart_ctrl_asserts.sv
`timescale 1ns/1ps

module hart_ctrl_asserts import hart_pkg::*; (
    input logic                clk,
    input logic                i_rst,
    input logic [HART_NUM-1:0] i_prim,
    input logic [HART_NUM-1:0] i_acti,
    input logic                i_ic_flush,
    input logic                i_dc_flush,
    input logic                i_ic_stall,
    input logic                i_dc_stall
);

    prim_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_prim))
        else $error("primary hart vector has more than one bit set");

    // New primary was picked from the harts active in the cycle before
    prim_from_active: assert property (@(posedge clk) disable iff (i_rst)
        (i_prim != '0 && i_prim != $past(i_prim)) |-> ((i_prim & $past(i_acti)) != '0))
        else $error("primary hart switched to a hart that was not active");

    // Flush needs a runnable hart, stall needs none
    ic_no_overlap: assert property (@(posedge clk) disable iff (i_rst)
        !(i_ic_flush && i_ic_stall))
        else $error("i-cache flush and stall raised together");

    dc_no_overlap: assert property (@(posedge clk) disable iff (i_rst)
        !(i_dc_flush && i_dc_stall))
        else $error("d-cache flush and stall raised together");

endmodule

bind hart_switch hart_ctrl_asserts u_asserts (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_prim     (prim_q),
    .i_acti     (acti),
    .i_ic_flush (o_hart_ic_flush),
    .i_dc_flush (o_hart_dc_flush),
    .i_ic_stall (sched.ic_stall),
    .i_dc_stall (sched.dc_stall)
);

//--- verif/hart_ctrl_tb.sv
`timescale 1ns/1ps

module hart_ctrl_tb import hart_pkg::*; ();

    localparam logic [3:0] OP_NOP = 4'd0, OP_START = 4'd1, OP_KILL = 4'd2, OP_ICMISS = 4'd3;
    localparam logic [3:0] OP_ICFIN = 4'd4, OP_DCMISS = 4'd5, OP_DCFIN = 4'd6;
    localparam logic [3:0] OP_BRANCH = 4'd7, OP_LOAD = 4'd8;
    localparam logic [3:0] OP_KFIN = 4'd9;  // Kill and d-cache finish together

    typedef struct packed {
        logic [3:0]            op;
        logic [HART_ID_W-1:0]  hid;
        logic [HART_SST_W-1:0] val;   // o_hart_val while the row is applied
        logic [HART_NUM-1:0]   acti;  // o_acti_hstate one cycle later
    } row_t;

    localparam int NROWS   = 35;
    localparam int TIMEOUT = NROWS + 3 + 20;

    localparam row_t TBL [NROWS] = '{
        '{OP_START,  2'd1, SST_IDLE,   4'b0011}, '{OP_START,  2'd1, SST_ACTIVE, 4'b0011},
        '{OP_START,  2'd2, SST_IDLE,   4'b0111}, '{OP_BRANCH, 2'd0, SST_ACTIVE, 4'b0111},
        '{OP_BRANCH, 2'd1, SST_ACTIVE, 4'b0111}, '{OP_BRANCH, 2'd2, SST_ACTIVE, 4'b0111},
        '{OP_BRANCH, 2'd3, SST_IDLE,   4'b0111}, '{OP_KILL,   2'd2, SST_ACTIVE, 4'b0011},
        '{OP_KILL,   2'd1, SST_ACTIVE, 4'b0001}, '{OP_BRANCH, 2'd0, SST_ACTIVE, 4'b0001},
        '{OP_START,  2'd3, SST_IDLE,   4'b1001}, '{OP_ICMISS, 2'd0, SST_ACTIVE, 4'b1000},
        '{OP_NOP,    2'd0, SST_PEND,   4'b1000}, '{OP_DCFIN,  2'd0, SST_PEND,   4'b1000},
        '{OP_ICFIN,  2'd0, SST_PEND,   4'b1001}, '{OP_DCMISS, 2'd3, SST_ACTIVE, 4'b0001},
        '{OP_NOP,    2'd3, SST_PEND,   4'b0001}, '{OP_DCMISS, 2'd0, SST_ACTIVE, 4'b0000},
        '{OP_NOP,    2'd0, SST_PEND,   4'b0000}, '{OP_ICFIN,  2'd0, SST_PEND,   4'b0000},
        '{OP_DCFIN,  2'd0, SST_PEND,   4'b0001}, '{OP_NOP,    2'd0, SST_ACTIVE, 4'b0001},
        '{OP_START,  2'd1, SST_IDLE,   4'b0011}, '{OP_DCFIN,  2'd3, SST_PEND,   4'b1011},
        '{OP_DCMISS, 2'd1, SST_ACTIVE, 4'b1001}, '{OP_KFIN,   2'd1, SST_PEND,   4'b1001},
        '{OP_NOP,    2'd1, SST_IDLE,   4'b1001}, '{OP_LOAD,   2'd0, SST_ACTIVE, 4'b1001},
        '{OP_KILL,   2'd3, SST_ACTIVE, 4'b0001}, '{OP_NOP,    2'd0, SST_ACTIVE, 4'b0001},
        '{OP_ICMISS, 2'd0, SST_ACTIVE, 4'b0000}, '{OP_NOP,    2'd0, SST_PEND,   4'b0000},
        '{OP_ICFIN,  2'd0, SST_PEND,   4'b0001}, '{OP_KILL,   2'd0, SST_ACTIVE, 4'b0000},
        '{OP_NOP,    2'd0, SST_IDLE,   4'b0000}
    };

    logic clk = 1'b0;
    logic i_rst, i_id_hstart, i_id_hkill, i_is_branch, i_is_load;
    logic i_icache_miss, i_icache_fin, i_dcache_miss, i_dcache_fin;
    logic [HART_ID_W-1:0]  i_id_set_hid, i_if_hart_id, i_icache_fin_hid;
    logic [HART_ID_W-1:0]  i_ex_hart_id, i_dcache_fin_hid, o_issue_hid;
    logic [HART_SST_W-1:0] o_hart_val;
    logic [HART_NUM-1:0]   o_acti_hstate, o_idle_hstate, o_issue_hstate;
    logic o_hart_idle, o_hart_ic_stall, o_hart_dc_stall, o_hart_ic_flush, o_hart_dc_flush;

    // Reference model of the run states and the primary hart
    logic [HART_SST_W-1:0] m_st [HART_NUM];
    logic [HART_NUM-1:0]   m_pdc;       // Pending on the d-cache rather than the i-cache
    logic [HART_NUM-1:0]   m_prim;

    int n_pass = 0;
    int n_fail = 0;
    int cycles = 0;
    int row_err [NROWS+1];              // Last slot holds the reset checks

    hart_ctrl uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, the table never finished", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_val(input int row, input string name, input int got, input int exp);
        assert (got == exp) n_pass++;
        else begin
            n_fail++;
            row_err[row]++;
            $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    function automatic logic [HART_NUM-1:0] model_acti();
        logic [HART_NUM-1:0] v;
        for (int h = 0; h < HART_NUM; h++) begin
            v[h] = (m_st[h] == SST_ACTIVE);
        end
        return v;
    endfunction

    function automatic logic [HART_NUM-1:0] model_pend(input logic on_dc);
        logic [HART_NUM-1:0] v;
        for (int h = 0; h < HART_NUM; h++) begin
            v[h] = (m_st[h] == SST_PEND) && (m_pdc[h] == on_dc);
        end
        return v;
    endfunction

    function automatic int model_prim_id();
        int id;
        id = 0;
        for (int h = 0; h < HART_NUM; h++) begin
            if (m_prim[h]) id = h;
        end
        return id;
    endfunction

    task automatic check_model(input int row, input logic [3:0] op, input int hid);
        logic [HART_NUM-1:0] acti;
        logic [HART_NUM-1:0] idle;
        int                  pid;
        logic                ic_stall;
        logic                dc_stall;
        logic                ic_flush;
        logic                dc_flush;
        acti     = model_acti();
        pid      = model_prim_id();
        ic_stall = (acti == '0) && (model_pend(1'b0) != '0);
        dc_stall = (acti == '0) && (model_pend(1'b1) != '0);
        // Miss taken by an active hart, flush only if another hart can run
        ic_flush = (op == OP_ICMISS) && (m_prim != '0) && acti[pid] && ((acti & ~m_prim) != '0);
        dc_flush = (op == OP_DCMISS) && acti[hid] && ((acti & ~HART_NUM'(1 << hid)) != '0);
        for (int h = 0; h < HART_NUM; h++) begin
            idle[h] = (m_st[h] == SST_IDLE);
        end
        check_val(row, "o_issue_hstate", int'(o_issue_hstate), int'(m_prim));
        if (m_prim != '0) check_val(row, "o_issue_hid", int'(o_issue_hid), pid);
        check_val(row, "o_idle_hstate", int'(o_idle_hstate), int'(idle));
        check_val(row, "o_hart_ic_stall", int'(o_hart_ic_stall), int'(ic_stall));
        check_val(row, "o_hart_dc_stall", int'(o_hart_dc_stall), int'(dc_stall));
        check_val(row, "o_hart_ic_flush", int'(o_hart_ic_flush), int'(ic_flush));
        check_val(row, "o_hart_dc_flush", int'(o_hart_dc_flush), int'(dc_flush));
    endtask

    task automatic model_step(input logic [3:0] op, input int hid);
        logic [HART_NUM-1:0] acti;
        logic [HART_NUM-1:0] nprim;
        int                  pid;
        int                  cand;
        logic                stalled;
        logic                sw;
        acti    = model_acti();
        pid     = model_prim_id();
        stalled = (acti == '0) && ((model_pend(1'b0) | model_pend(1'b1)) != '0);
        for (int h = 0; h < HART_NUM; h++) begin
            if ((op == OP_KILL || op == OP_KFIN) && h == hid) begin
                m_st[h] = SST_IDLE;
            end else if (op == OP_ICMISS && m_prim != '0 && h == pid && acti[h]) begin
                m_st[h]  = SST_PEND;
                m_pdc[h] = 1'b0;
            end else if (op == OP_DCMISS && h == hid && acti[h]) begin
                m_st[h]  = SST_PEND;
                m_pdc[h] = 1'b1;
            end else if (op == OP_ICFIN && h == hid && m_st[h] == SST_PEND && !m_pdc[h]) begin
                m_st[h] = SST_ACTIVE;
            end else if (op == OP_DCFIN && h == hid && m_st[h] == SST_PEND && m_pdc[h]) begin
                m_st[h] = SST_ACTIVE;
            end else if (op == OP_START && h == hid && m_st[h] == SST_IDLE) begin
                m_st[h] = SST_ACTIVE;
            end
        end
        // Primary moves on when lost, or on a branch or load from the issue hart
        sw = (op == OP_BRANCH || op == OP_LOAD) && m_prim != '0 && hid == pid && !stalled;
        if (m_prim == '0 || !acti[pid] || sw) begin
            nprim = '0;
            for (int s = HART_NUM; s >= 1; s--) begin
                cand = (pid + s) % HART_NUM;
                if (acti[cand]) nprim = HART_NUM'(1 << cand);  // Nearest hart wins
            end
            m_prim = nprim;
        end
    endtask

    task automatic drive_row(input row_t r);
        i_id_hstart   <= (r.op == OP_START);
        i_id_hkill    <= (r.op == OP_KILL) || (r.op == OP_KFIN);
        i_icache_miss <= (r.op == OP_ICMISS);
        i_icache_fin  <= (r.op == OP_ICFIN);
        i_dcache_miss <= (r.op == OP_DCMISS);
        i_dcache_fin  <= (r.op == OP_DCFIN) || (r.op == OP_KFIN);
        i_is_branch   <= (r.op == OP_BRANCH);
        i_is_load     <= (r.op == OP_LOAD);
        i_id_set_hid     <= r.hid;
        i_if_hart_id     <= r.hid;
        i_icache_fin_hid <= r.hid;
        i_ex_hart_id     <= r.hid;
        i_dcache_fin_hid <= r.hid;
    endtask

    task automatic report_row(input int idx);
        $display("row %0d op %0d hart %0d: %s", idx, TBL[idx].op, TBL[idx].hid,
                 (row_err[idx] == 0) ? "ok" : "FAIL");
    endtask

    initial begin
        {i_id_hstart, i_id_hkill, i_is_branch, i_is_load} = '0;
        {i_icache_miss, i_icache_fin, i_dcache_miss, i_dcache_fin} = '0;
        {i_id_set_hid, i_if_hart_id, i_icache_fin_hid, i_ex_hart_id, i_dcache_fin_hid} = '0;
        i_rst = 1'b1;
        for (int h = 0; h < HART_NUM; h++) begin
            m_st[h] = (h == int'(RESET_HART)) ? SST_ACTIVE : SST_IDLE;
        end
        m_pdc  = '0;
        m_prim = '0;
        repeat (3) @(posedge clk);
        i_rst <= 1'b0;
        @(negedge clk);
        check_model(NROWS, OP_NOP, 0);  // No issue hart yet
        model_step(OP_NOP, 0);
        $display("after reset: %s", (row_err[NROWS] == 0) ? "ok" : "FAIL");
        for (int k = 0; k < NROWS; k++) begin
            @(posedge clk);
            drive_row(TBL[k]);
            @(negedge clk);
            if (k > 0) check_val(k - 1, "o_acti_hstate", int'(o_acti_hstate), int'(TBL[k-1].acti));
            check_val(k, "o_hart_val", int'(o_hart_val), int'(TBL[k].val));
            check_val(k, "o_hart_idle", int'(o_hart_idle), int'(TBL[k].val == SST_IDLE));
            check_model(k, TBL[k].op, int'(TBL[k].hid));
            model_step(TBL[k].op, int'(TBL[k].hid));
            if (k > 0) report_row(k - 1);
        end
        @(posedge clk);
        drive_row('{OP_NOP, 2'd0, SST_IDLE, 4'b0000});
        @(negedge clk);
        check_val(NROWS - 1, "o_acti_hstate", int'(o_acti_hstate), int'(TBL[NROWS-1].acti));
        check_model(NROWS - 1, OP_NOP, 0);
        report_row(NROWS - 1);
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
common/hart_pkg.sv
common/hart_sched_if.sv
hart_state/hart_state.sv
hart_switch/hart_switch.sv
design/hart_ctrl.sv
verif/hart_ctrl_asserts.sv
verif/hart_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hart controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module hart_ctrl_tb -Mdir obj_dir -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vhart_ctrl_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
